// File: Makefile
# Verilator flow for the MSHR memory port testbench

TOP := mshr_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mshr_mem.f logic/*.sv verif/*.sv
	verilator --binary --assert --timescale 1ns/1ns -f mshr_mem.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -x -F '** PASS **' sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns -f mshr_mem.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: logic/mem_fixed_priority_arbiter.sv
// Index 0 has the highest priority, no fairness between requesters
// A grant stays held until ack_i and is released at that edge

`timescale 1ns/1ns

module mem_fixed_priority_arbiter (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [mshr_pkg::MSHR_NUM-1:0]   req_i,
    input  logic                            ack_i,
    output logic [mshr_pkg::MSHR_IDX_W-1:0] grant_o,
    output logic                            valid_o
);

    logic                            held_q;
    logic [mshr_pkg::MSHR_IDX_W-1:0] held_idx_q;
    logic [mshr_pkg::MSHR_IDX_W-1:0] low_idx;

    // Lowest set request bit, scanned from the top down
    always_comb begin
        low_idx = '0;
        for (int i = mshr_pkg::MSHR_NUM - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                low_idx = i[mshr_pkg::MSHR_IDX_W-1:0];
            end
        end
    end

    // Held index wins, otherwise a fresh pick
    assign grant_o = held_q ? held_idx_q : low_idx;
    assign valid_o = held_q | (|req_i);

    // Hold flag, set on an unacknowledged grant
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_q <= 1'b0;
        end else if (ack_i) begin
            held_q <= 1'b0;
        end else if (valid_o) begin
            held_q <= 1'b1;
        end
    end

    // Index follows the fresh pick until held
    always_ff @(posedge clk_i) begin
        if (!held_q) begin
            held_idx_q <= low_idx;
        end
    end

    // Grant must not move while memory has not answered
    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_o && !ack_i) |=> (valid_o && (grant_o == $past(grant_o))));

endmodule

// File: logic/mem_switch.sv
// Shares one memory port among C_REQ_NUM requesters
// C_REQ_NUM must equal MSHR_NUM because the arbiter is sized from the package

`timescale 1ns/1ns

module mem_switch #(
    parameter int C_REQ_NUM = mshr_pkg::MSHR_NUM
) (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  mshr_pkg::bus_command_e [C_REQ_NUM-1:0]        req_cmd_i,
    input  logic [C_REQ_NUM-1:0][mshr_pkg::ADDR_W-1:0]    req_addr_i,
    input  logic [C_REQ_NUM-1:0][mshr_pkg::DATA_W-1:0]    req_data_i,
    input  logic [mshr_pkg::TAG_W-1:0]                    mem_response_i,
    output logic [C_REQ_NUM-1:0]                          memory_grant_o,
    output mshr_pkg::bus_command_e                        mem_command_o,
    output logic [mshr_pkg::ADDR_W-1:0]                   mem_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]                   mem_data_o
);

    logic [C_REQ_NUM-1:0]            arbiter_req;
    logic                            arbiter_ack;
    logic [mshr_pkg::MSHR_IDX_W-1:0] grant_idx;
    logic                            grant_valid;

    mem_fixed_priority_arbiter i_arbiter (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (arbiter_req),
        .ack_i   (arbiter_ack),
        .grant_o (grant_idx),
        .valid_o (grant_valid)
    );

    always_comb begin
        // Every requester with a live command competes
        arbiter_req = '0;
        for (int unsigned i = 0; i < C_REQ_NUM; i++) begin
            if (req_cmd_i[i] != mshr_pkg::BUS_NONE) begin
                arbiter_req[i] = 1'b1;
            end
        end

        // Nonzero response ends the held grant
        arbiter_ack = grant_valid && (mem_response_i != '0);

        // Idle port when nobody is granted
        mem_command_o  = mshr_pkg::BUS_NONE;
        mem_addr_o     = '0;
        mem_data_o     = '0;
        memory_grant_o = '0;
        if (grant_valid) begin
            mem_command_o  = req_cmd_i[grant_idx];
            mem_addr_o     = req_addr_i[grant_idx];
            mem_data_o     = req_data_i[grant_idx];
            memory_grant_o = {{(C_REQ_NUM-1){1'b0}}, 1'b1} << grant_idx;
        end
    end

    // At most one entry owns the port and it must still be requesting
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(memory_grant_o) && ((memory_grant_o & ~arbiter_req) == '0));

endmodule

// File: logic/mshr_ctrl.sv
// Allocates misses to the lowest free entry
// Completion outputs are registered, one cycle after the entry's tag hit

`timescale 1ns/1ns

module mshr_ctrl (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  logic                                                  miss_valid_i,
    input  logic [mshr_pkg::MSHR_NUM-1:0]                         busy_i,
    input  logic [mshr_pkg::MSHR_NUM-1:0]                         done_i,
    input  logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::ADDR_W-1:0]   entry_done_addr_i,
    input  logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::DATA_W-1:0]   entry_done_data_i,
    output logic [mshr_pkg::MSHR_NUM-1:0]                         alloc_o,
    output logic                                                  miss_ready_o,
    output logic                                                  done_valid_o,
    output logic [mshr_pkg::MSHR_IDX_W-1:0]                       done_idx_o,
    output logic [mshr_pkg::ADDR_W-1:0]                           done_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]                           done_data_o
);

    logic [mshr_pkg::MSHR_IDX_W-1:0] free_idx;
    logic [mshr_pkg::MSHR_IDX_W-1:0] done_idx;

    // ====================
    // Allocation
    // ====================
    always_comb begin
        free_idx = '0;
        // Top down so the lowest free entry wins
        for (int i = mshr_pkg::MSHR_NUM - 1; i >= 0; i--) begin
            if (!busy_i[i]) begin
                free_idx = i[mshr_pkg::MSHR_IDX_W-1:0];
            end
        end
    end

    // Ready while any entry is free
    assign miss_ready_o = ~(&busy_i);
    assign alloc_o = (miss_valid_i && miss_ready_o) ?
                     ({{(mshr_pkg::MSHR_NUM-1){1'b0}}, 1'b1} << free_idx) : '0;

    // ====================
    // Completion
    // ====================
    always_comb begin
        done_idx = '0;
        // At most one entry hits per cycle
        for (int i = 0; i < mshr_pkg::MSHR_NUM; i++) begin
            if (done_i[i]) begin
                done_idx = i[mshr_pkg::MSHR_IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_valid_o <= 1'b0;
        end else begin
            done_valid_o <= |done_i;
        end
    end

    // Completion payload, held between pulses
    always_ff @(posedge clk_i) begin
        if (|done_i) begin
            done_idx_o  <= done_idx;
            done_addr_o <= entry_done_addr_i[done_idx];
            done_data_o <= entry_done_data_i[done_idx];
        end
    end

    // Caller only strobes while ready
    a_miss_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        miss_valid_i |-> miss_ready_o);
    // Unique tags mean one hit per cycle
    a_done_single: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(done_i));

endmodule

// File: logic/mshr_entry.sv
// One miss-status entry, holds a single load or store miss
// Load data is handed out on the tag hit cycle, the control block registers it

`timescale 1ns/1ns

module mshr_entry (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // Allocation from the control block
    input  logic                          alloc_i,
    input  mshr_pkg::bus_command_e        cmd_i,
    input  logic [mshr_pkg::ADDR_W-1:0]   addr_i,
    input  logic [mshr_pkg::DATA_W-1:0]   data_i,
    // Memory side
    input  logic                          grant_i,
    input  logic [mshr_pkg::TAG_W-1:0]    mem_response_i,
    input  logic [mshr_pkg::TAG_W-1:0]    mem_tag_i,
    input  logic [mshr_pkg::DATA_W-1:0]   mem_data_i,
    // Status and request
    output logic                          busy_o,
    output mshr_pkg::bus_command_e        req_cmd_o,
    output logic [mshr_pkg::ADDR_W-1:0]   req_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]   req_data_o,
    // Completion
    output logic                          done_o,
    output logic [mshr_pkg::ADDR_W-1:0]   done_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]   done_data_o
);

    logic [1:0]                    state_q;
    mshr_pkg::bus_command_e        cmd_q;
    logic [mshr_pkg::ADDR_W-1:0]   addr_q;
    logic [mshr_pkg::DATA_W-1:0]   data_q;
    logic [mshr_pkg::TAG_W-1:0]    tag_q;
    logic                          accepted;
    logic                          tag_hit;

    // Granted and memory gave a tag
    assign accepted = (state_q == mshr_pkg::ENTRY_REQ) && grant_i && (mem_response_i != '0);
    // Stored tag is never 0, so an idle tag bus cannot hit
    assign tag_hit = (state_q == mshr_pkg::ENTRY_WAIT) && (mem_tag_i == tag_q);

    // ====================
    // Entry FSM
    // ====================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= mshr_pkg::ENTRY_IDLE;
        end else begin
            case (state_q)
                mshr_pkg::ENTRY_IDLE: begin
                    if (alloc_i) begin
                        state_q <= mshr_pkg::ENTRY_REQ;
                    end
                end
                mshr_pkg::ENTRY_REQ: begin
                    // Store is finished once memory takes it
                    if (accepted) begin
                        state_q <= (cmd_q == mshr_pkg::BUS_STORE) ?
                                   mshr_pkg::ENTRY_IDLE : mshr_pkg::ENTRY_WAIT;
                    end
                end
                mshr_pkg::ENTRY_WAIT: begin
                    if (tag_hit) begin
                        state_q <= mshr_pkg::ENTRY_DONE;
                    end
                end
                // Retire cycle, matches the registered completion pulse
                default: begin
                    state_q <= mshr_pkg::ENTRY_IDLE;
                end
            endcase
        end
    end

    // Miss payload
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            cmd_q  <= cmd_i;
            addr_q <= addr_i;
            data_q <= data_i;
        end
    end

    // Tag from the accepting response
    always_ff @(posedge clk_i) begin
        if (accepted) begin
            tag_q <= mem_response_i;
        end
    end

    assign busy_o      = (state_q != mshr_pkg::ENTRY_IDLE);
    // Request only while in the request state
    assign req_cmd_o   = (state_q == mshr_pkg::ENTRY_REQ) ? cmd_q : mshr_pkg::BUS_NONE;
    assign req_addr_o  = addr_q;
    assign req_data_o  = data_q;
    assign done_o      = tag_hit;
    assign done_addr_o = addr_q;
    assign done_data_o = mem_data_i;

    // Control block must pick a free entry and a real command
    a_alloc_free: assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_i |-> ((state_q == mshr_pkg::ENTRY_IDLE) && (cmd_i != mshr_pkg::BUS_NONE)));

endmodule

// File: logic/mshr_pkg.sv
// Sizing and bus encodings shared by the miss-handling memory port
// Response tag 0 means no response, so at most 15 loads can be outstanding

package mshr_pkg;

    // ====================
    // Sizing
    // ====================

    // Number of miss-status entries
    localparam int MSHR_NUM   = 4;
    // Entry index width, must cover MSHR_NUM
    localparam int MSHR_IDX_W = 2;
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 64;
    // Memory tag width, tag 0 is reserved
    localparam int TAG_W      = 4;

    // ====================
    // Encodings
    // ====================

    // Command on the memory port
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // Entry FSM state codes
    localparam logic [1:0] ENTRY_IDLE = 2'h0;
    localparam logic [1:0] ENTRY_REQ  = 2'h1;
    localparam logic [1:0] ENTRY_WAIT = 2'h2;
    localparam logic [1:0] ENTRY_DONE = 2'h3;

endpackage

// File: logic/mshr_top.sv
// Miss-handling memory port, MSHR_NUM entries sharing one memory port
// Stores complete silently, loads report on done_valid_o

`timescale 1ns/1ns

module mshr_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Miss side
    input  logic                            miss_valid_i,
    input  mshr_pkg::bus_command_e          miss_cmd_i,
    input  logic [mshr_pkg::ADDR_W-1:0]     miss_addr_i,
    input  logic [mshr_pkg::DATA_W-1:0]     miss_data_i,
    output logic                            miss_ready_o,
    // Completion side
    output logic                            done_valid_o,
    output logic [mshr_pkg::MSHR_IDX_W-1:0] done_idx_o,
    output logic [mshr_pkg::ADDR_W-1:0]     done_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]     done_data_o,
    // Memory side
    output mshr_pkg::bus_command_e          mem_command_o,
    output logic [mshr_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic [mshr_pkg::DATA_W-1:0]     mem_data_o,
    input  logic [mshr_pkg::TAG_W-1:0]      mem_response_i,
    input  logic [mshr_pkg::TAG_W-1:0]      mem_tag_i,
    input  logic [mshr_pkg::DATA_W-1:0]     mem_data_i
);

    logic [mshr_pkg::MSHR_NUM-1:0]                        alloc;
    logic [mshr_pkg::MSHR_NUM-1:0]                        busy;
    logic [mshr_pkg::MSHR_NUM-1:0]                        grant;
    logic [mshr_pkg::MSHR_NUM-1:0]                        done;
    mshr_pkg::bus_command_e [mshr_pkg::MSHR_NUM-1:0]      req_cmd;
    logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::ADDR_W-1:0]  req_addr;
    logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::DATA_W-1:0]  req_data;
    logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::ADDR_W-1:0]  done_addr;
    logic [mshr_pkg::MSHR_NUM-1:0][mshr_pkg::DATA_W-1:0]  done_data;

    mshr_ctrl i_ctrl (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .miss_valid_i      (miss_valid_i),
        .busy_i            (busy),
        .done_i            (done),
        .entry_done_addr_i (done_addr),
        .entry_done_data_i (done_data),
        .alloc_o           (alloc),
        .miss_ready_o      (miss_ready_o),
        .done_valid_o      (done_valid_o),
        .done_idx_o        (done_idx_o),
        .done_addr_o       (done_addr_o),
        .done_data_o       (done_data_o)
    );

    // Miss fields broadcast, alloc picks the entry
    for (genvar g = 0; g < mshr_pkg::MSHR_NUM; g++) begin : g_entry
        mshr_entry i_entry (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .alloc_i        (alloc[g]),
            .cmd_i          (miss_cmd_i),
            .addr_i         (miss_addr_i),
            .data_i         (miss_data_i),
            .grant_i        (grant[g]),
            .mem_response_i (mem_response_i),
            .mem_tag_i      (mem_tag_i),
            .mem_data_i     (mem_data_i),
            .busy_o         (busy[g]),
            .req_cmd_o      (req_cmd[g]),
            .req_addr_o     (req_addr[g]),
            .req_data_o     (req_data[g]),
            .done_o         (done[g]),
            .done_addr_o    (done_addr[g]),
            .done_data_o    (done_data[g])
        );
    end

    mem_switch #(
        .C_REQ_NUM (mshr_pkg::MSHR_NUM)
    ) i_switch (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_cmd_i      (req_cmd),
        .req_addr_i     (req_addr),
        .req_data_i     (req_data),
        .mem_response_i (mem_response_i),
        .memory_grant_o (grant),
        .mem_command_o  (mem_command_o),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o)
    );

endmodule

// File: mshr_mem.f
logic/mshr_pkg.sv
logic/mem_fixed_priority_arbiter.sv
logic/mem_switch.sv
logic/mshr_entry.sv
logic/mshr_ctrl.sv
logic/mshr_top.sv
verif/mem_responder.sv
verif/mshr_tb.sv

// File: verif/mem_responder.sv
// Behavioral memory for the testbench, one accepted command per cycle
// Accepts at random, load data returns 1 to 8 cycles later in any order
// Stores and load reads take effect at the acceptance edge

`timescale 1ns/1ns

module mem_responder #(
    parameter int SEED = 32'h5d5e
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  mshr_pkg::bus_command_e        mem_command_i,
    input  logic [mshr_pkg::ADDR_W-1:0]   mem_addr_i,
    input  logic [mshr_pkg::DATA_W-1:0]   mem_data_i,
    output logic [mshr_pkg::TAG_W-1:0]    mem_response_o,
    output logic [mshr_pkg::TAG_W-1:0]    mem_tag_o,
    output logic [mshr_pkg::DATA_W-1:0]   mem_data_o
);

    localparam int TAG_NUM = 1 << mshr_pkg::TAG_W;

    int                          seed;
    logic [mshr_pkg::DATA_W-1:0] mem [logic [mshr_pkg::ADDR_W-1:0]];
    // Outstanding loads, indexed by tag
    bit                          pend_valid [TAG_NUM];
    int                          pend_wait  [TAG_NUM];
    logic [mshr_pkg::DATA_W-1:0] pend_data  [TAG_NUM];

    // Untouched words hold a pattern of their full address
    function automatic logic [mshr_pkg::DATA_W-1:0] read_word(
        input logic [mshr_pkg::ADDR_W-1:0] addr
    );
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr, ~addr, addr ^ 16'h3c3c, addr + 16'h1357};
    endfunction

    // Edge sampling, values seen by the DUT at this edge
    task automatic take_edge();
        // Tag returned last cycle is free again
        if (mem_tag_o != '0) begin
            pend_valid[mem_tag_o] = 1'b0;
        end
        if (mem_command_i != mshr_pkg::BUS_NONE && mem_response_o != '0) begin
            if (mem_command_i == mshr_pkg::BUS_STORE) begin
                mem[mem_addr_i] = mem_data_i;
            end else begin
                pend_valid[mem_response_o] = 1'b1;
                pend_wait[mem_response_o]  = 1 + $unsigned($random(seed)) % 8;
                pend_data[mem_response_o]  = read_word(mem_addr_i);
            end
        end
    endtask

    task automatic drive_cycle();
        int ret_tag;
        int offer;
        int start;
        int t;
        ret_tag = 0;
        offer   = 0;
        // Count down, first ripe tag goes back
        for (int i = 1; i < TAG_NUM; i++) begin
            if (pend_valid[i] && pend_wait[i] > 0) begin
                pend_wait[i]--;
            end
            if (pend_valid[i] && pend_wait[i] == 0 && ret_tag == 0) begin
                ret_tag = i;
            end
        end
        // Half the cycles offer a free tag, random start
        start = $unsigned($random(seed)) % (TAG_NUM - 1);
        if ($unsigned($random(seed)) % 2 == 0) begin
            for (int k = 0; k < TAG_NUM - 1; k++) begin
                t = 1 + (start + k) % (TAG_NUM - 1);
                if (!pend_valid[t] && offer == 0) begin
                    offer = t;
                end
            end
        end
        mem_response_o = offer[mshr_pkg::TAG_W-1:0];
        mem_tag_o      = ret_tag[mshr_pkg::TAG_W-1:0];
        // Junk on the data bus between returns
        if (ret_tag != 0) begin
            mem_data_o = pend_data[ret_tag];
        end else begin
            mem_data_o = {$random(seed), $random(seed)};
        end
    endtask

    initial begin
        seed           = SEED;
        mem_response_o = '0;
        mem_tag_o      = '0;
        mem_data_o     = '0;
        for (int i = 0; i < TAG_NUM; i++) begin
            pend_valid[i] = 1'b0;
            pend_wait[i]  = 0;
        end
        forever begin
            @(posedge clk_i);
            if (!rst_i) begin
                take_edge();
            end
            #2;
            if (rst_i) begin
                mem_response_o = '0;
                mem_tag_o      = '0;
            end else begin
                drive_cycle();
            end
        end
    end

endmodule

// File: verif/mshr_tb.sv
// Random load and store misses checked against a model of entries, arbiter and memory
// Stops at the first mismatch
// Watchdog limit scales with MISS_COUNT

`timescale 1ns/1ns

module mshr_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MISS_COUNT   = 600;
    localparam int WATCHDOG_NS  = MISS_COUNT * 40 * CLK_PERIOD;

    // Model entry states
    localparam int M_IDLE = 0;
    localparam int M_REQ  = 1;
    localparam int M_WAIT = 2;
    localparam int M_DONE = 3;

    logic                            clk;
    logic                            rst;
    logic                            miss_valid;
    mshr_pkg::bus_command_e          miss_cmd;
    logic [mshr_pkg::ADDR_W-1:0]     miss_addr;
    logic [mshr_pkg::DATA_W-1:0]     miss_data;
    logic                            miss_ready;
    logic                            done_valid;
    logic [mshr_pkg::MSHR_IDX_W-1:0] done_idx;
    logic [mshr_pkg::ADDR_W-1:0]     done_addr;
    logic [mshr_pkg::DATA_W-1:0]     done_data;
    mshr_pkg::bus_command_e          mem_command;
    logic [mshr_pkg::ADDR_W-1:0]     mem_addr;
    logic [mshr_pkg::DATA_W-1:0]     mem_wdata;
    logic [mshr_pkg::TAG_W-1:0]      mem_response;
    logic [mshr_pkg::TAG_W-1:0]      mem_tag;
    logic [mshr_pkg::DATA_W-1:0]     mem_rdata;

    int seed;

    // ====================
    // Reference model
    // ====================
    int                              ent_state [mshr_pkg::MSHR_NUM];
    mshr_pkg::bus_command_e          ent_cmd   [mshr_pkg::MSHR_NUM];
    logic [mshr_pkg::ADDR_W-1:0]     ent_addr  [mshr_pkg::MSHR_NUM];
    logic [mshr_pkg::DATA_W-1:0]     ent_data  [mshr_pkg::MSHR_NUM];
    logic [mshr_pkg::DATA_W-1:0]     ent_exp   [mshr_pkg::MSHR_NUM];
    logic [mshr_pkg::TAG_W-1:0]      ent_tag   [mshr_pkg::MSHR_NUM];
    logic [mshr_pkg::DATA_W-1:0]     model_mem [logic [mshr_pkg::ADDR_W-1:0]];
    bit                              hold_valid;
    int                              hold_idx;
    // Completion expected on the next edge
    bit                              done_due;
    logic [mshr_pkg::MSHR_IDX_W-1:0] done_due_idx;
    logic [mshr_pkg::ADDR_W-1:0]     done_due_addr;
    logic [mshr_pkg::DATA_W-1:0]     done_due_data;
    int                              misses_sent;
    int                              loads_issued;
    int                              loads_done;
    bit                              finished;

    mshr_top i_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .miss_valid_i   (miss_valid),
        .miss_cmd_i     (miss_cmd),
        .miss_addr_i    (miss_addr),
        .miss_data_i    (miss_data),
        .miss_ready_o   (miss_ready),
        .done_valid_o   (done_valid),
        .done_idx_o     (done_idx),
        .done_addr_o    (done_addr),
        .done_data_o    (done_data),
        .mem_command_o  (mem_command),
        .mem_addr_o     (mem_addr),
        .mem_data_o     (mem_wdata),
        .mem_response_i (mem_response),
        .mem_tag_i      (mem_tag),
        .mem_data_i     (mem_rdata)
    );

    mem_responder #(
        .SEED (32'h5d5e)
    ) i_mem (
        .clk_i          (clk),
        .rst_i          (rst),
        .mem_command_i  (mem_command),
        .mem_addr_i     (mem_addr),
        .mem_data_i     (mem_wdata),
        .mem_response_o (mem_response),
        .mem_tag_o      (mem_tag),
        .mem_data_o     (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input logic [mshr_pkg::DATA_W-1:0] exp,
                              input logic [mshr_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [mshr_pkg::ADDR_W-1:0] exp,
                              input logic [mshr_pkg::ADDR_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_idx(input string name, input logic [mshr_pkg::MSHR_IDX_W-1:0] exp,
                             input logic [mshr_pkg::MSHR_IDX_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_cmd(input string name, input mshr_pkg::bus_command_e exp,
                             input mshr_pkg::bus_command_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %s, actual %s", name, exp.name(),
                                act.name()));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Same address pattern the memory starts from
    function automatic logic [mshr_pkg::DATA_W-1:0] model_word(
        input logic [mshr_pkg::ADDR_W-1:0] addr
    );
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        return {addr, ~addr, addr ^ 16'h3c3c, addr + 16'h1357};
    endfunction

    function automatic int busy_count();
        int n;
        n = 0;
        for (int i = 0; i < mshr_pkg::MSHR_NUM; i++) begin
            if (ent_state[i] != M_IDLE) begin
                n++;
            end
        end
        return n;
    endfunction

    // One model edge that checks the cycle ending here
    task automatic step_model();
        int                     grant;
        int                     alloc;
        int                     hit;
        mshr_pkg::bus_command_e exp_cmd;
        grant   = -1;
        alloc   = -1;
        hit     = -1;
        exp_cmd = mshr_pkg::BUS_NONE;

        // Ready low only with every entry busy
        check_flag("miss ready", busy_count() != mshr_pkg::MSHR_NUM, miss_ready);
        check_flag("done valid", done_due, done_valid);
        if (done_due) begin
            check_idx("done index", done_due_idx, done_idx);
            check_addr("done address", done_due_addr, done_addr);
            check_data("load data", done_due_data, done_data);
            loads_done++;
            done_due = 1'b0;
        end

        // Port owner is the held grant or else the lowest requester
        if (hold_valid) begin
            grant = hold_idx;
        end else begin
            for (int i = mshr_pkg::MSHR_NUM - 1; i >= 0; i--) begin
                if (ent_state[i] == M_REQ) begin
                    grant = i;
                end
            end
        end
        if (grant >= 0) begin
            exp_cmd = ent_cmd[grant];
        end
        check_cmd("port command", exp_cmd, mem_command);
        // Stalled cycles keep the held entry, so its fields must not move
        if (grant >= 0) begin
            check_addr("port address", ent_addr[grant], mem_addr);
            check_data("port data", ent_data[grant], mem_wdata);
        end

        // Lowest free entry before this edge
        for (int i = mshr_pkg::MSHR_NUM - 1; i >= 0; i--) begin
            if (ent_state[i] == M_IDLE) begin
                alloc = i;
            end
        end
        for (int i = 0; i < mshr_pkg::MSHR_NUM; i++) begin
            if (ent_state[i] == M_DONE) begin
                ent_state[i] = M_IDLE;
            end
        end

        // Completions follow tag return order
        if (mem_tag != '0) begin
            for (int i = 0; i < mshr_pkg::MSHR_NUM; i++) begin
                if (ent_state[i] == M_WAIT && ent_tag[i] == mem_tag) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                abort_run($sformatf("Memory returned tag %0d but no entry waits for it",
                                    mem_tag));
            end else begin
                ent_state[hit] = M_DONE;
                done_due       = 1'b1;
                done_due_idx   = hit[mshr_pkg::MSHR_IDX_W-1:0];
                done_due_addr  = ent_addr[hit];
                done_due_data  = ent_exp[hit];
            end
        end

        // Acceptance ends the hold and applies a store
        if (grant >= 0 && mem_response != '0) begin
            hold_valid = 1'b0;
            if (ent_cmd[grant] == mshr_pkg::BUS_STORE) begin
                model_mem[ent_addr[grant]] = ent_data[grant];
                ent_state[grant] = M_IDLE;
            end else begin
                ent_tag[grant]   = mem_response;
                ent_exp[grant]   = model_word(ent_addr[grant]);
                ent_state[grant] = M_WAIT;
            end
        end else if (grant >= 0) begin
            hold_valid = 1'b1;
            hold_idx   = grant;
        end

        if (miss_valid) begin
            if (alloc < 0) begin
                abort_run("Miss was strobed while every entry was busy");
            end else begin
                ent_state[alloc] = M_REQ;
                ent_cmd[alloc]   = miss_cmd;
                ent_addr[alloc]  = miss_addr;
                ent_data[alloc]  = miss_data;
                if (miss_cmd == mshr_pkg::BUS_LOAD) begin
                    loads_issued++;
                end
            end
        end
    endtask

    // Misses use a pool of 8 addresses with about 40 percent stores
    task automatic drive_miss();
        logic [31:0] rnd;
        miss_valid = 1'b0;
        if (misses_sent < MISS_COUNT && miss_ready && busy_count() < mshr_pkg::MSHR_NUM) begin
            if ($unsigned($random(seed)) % 4 != 0) begin
                rnd        = $random(seed);
                miss_valid = 1'b1;
                miss_cmd   = ($unsigned($random(seed)) % 5 < 2) ?
                             mshr_pkg::BUS_STORE : mshr_pkg::BUS_LOAD;
                miss_addr  = {{(mshr_pkg::ADDR_W - 6){1'b0}}, rnd[2:0], 3'b000};
                miss_data  = {$random(seed), $random(seed)};
                misses_sent++;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Watchdog expired after %0d ns, %0d of %0d loads done",
                            WATCHDOG_NS, loads_done, loads_issued));
    end

    initial begin
        seed         = 32'h5d5e;
        rst          = 1'b1;
        miss_valid   = 1'b0;
        miss_cmd     = mshr_pkg::BUS_NONE;
        miss_addr    = '0;
        miss_data    = '0;
        hold_valid   = 1'b0;
        hold_idx     = 0;
        done_due     = 1'b0;
        misses_sent  = 0;
        loads_issued = 0;
        loads_done   = 0;
        finished     = 1'b0;
        for (int i = 0; i < mshr_pkg::MSHR_NUM; i++) begin
            ent_state[i] = M_IDLE;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        // Quiet port right after reset
        check_cmd("reset command", mshr_pkg::BUS_NONE, mem_command);
        check_flag("reset done valid", 1'b0, done_valid);
        check_flag("reset miss ready", 1'b1, miss_ready);

        while (!finished) begin
            @(posedge clk);
            step_model();
            finished = (misses_sent == MISS_COUNT) && (busy_count() == 0) && !done_due;
            #2;
            drive_miss();
        end

        // Drained DUT shows a quiet port, free entries and no stray completion
        if (!done_valid && miss_ready && mem_command == mshr_pkg::BUS_NONE) begin
            $display("%0d misses, %0d loads completed", misses_sent, loads_done);
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("DUT was still active after every miss had completed");
        end
    end

endmodule
